/* source/dual_fetch_pkg.sv */
package dual_fetch_pkg;

	// Address, instruction and register index widths of the front end.
	localparam int ADDR_W = 32;
	localparam int INST_W = 32;
	localparam int PAIR_W = 2 * INST_W;
	localparam int REG_W  = 5;

	// The first pair is fetched from this address once reset is released.
	localparam logic [ADDR_W-1:0] RESET_PC = 32'h0000_0000;

	// One instruction is one word, and fetch always moves by a whole pair.
	localparam logic [ADDR_W-1:0] WORD_BYTES = 32'd4;
	localparam logic [ADDR_W-1:0] PAIR_BYTES = 32'd8;

	// Primary opcodes that the pairing logic knows about.
	// SPECIAL selects the register format, with the operation in funct.
	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_LW      = 6'b100011;
	localparam logic [5:0] OP_SW      = 6'b101011;
	localparam logic [5:0] OP_ADDIU   = 6'b001001;
	localparam logic [5:0] OP_BEQ     = 6'b000100;

	// One instruction word, seen either as a register or an immediate format.
	// The opcode, rs and rt fields sit at the same bits in both views.
	typedef union packed {
		struct packed {
			logic [5:0]       opcode;
			logic [REG_W-1:0] rs;
			logic [REG_W-1:0] rt;
			logic [REG_W-1:0] rd;
			logic [4:0]       shamt;
			logic [5:0]       funct;
		} r;
		struct packed {
			logic [5:0]       opcode;
			logic [REG_W-1:0] rs;
			logic [REG_W-1:0] rt;
			logic [15:0]      imm;
		} i;
	} inst_word_t;

endpackage

/* source/fetch_pc.sv */
module fetch_pc import dual_fetch_pkg::*; (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              stall,
	input  logic              hold,
	input  logic              flush,
	input  logic [ADDR_W-1:0] flush_target,
	output logic [ADDR_W-1:0] imem_addr,
	output logic              imem_en,
	input  logic [PAIR_W-1:0] imem_pair,
	output logic [ADDR_W-1:0] if_pc,
	output logic [PAIR_W-1:0] if_pair,
	output logic              if_valid
);

	// Address of the next pair to request.
	logic [ADDR_W-1:0] req_pc;
	// Address of the pair whose data is on imem_pair in this cycle.
	logic [ADDR_W-1:0] resp_pc;
	logic              resp_valid;
	logic              freeze;

	// Either a back-end stall or an alignment hold stops the fetch stream.
	assign freeze = stall | hold;

	// The memory reads on every edge, so a frozen cycle must ask for the
	// pair that is already in flight. That way the same data comes back
	// and still lines up with resp_pc.
	assign imem_addr = freeze ? resp_pc : req_pc;
	assign imem_en   = 1'b1;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			req_pc     <= RESET_PC;
			resp_pc    <= RESET_PC;
			resp_valid <= 1'b0;
		end
		else if (flush)
		begin
			// The request made at this edge is from the old path.
			// It is marked invalid, and the target goes out next cycle.
			req_pc     <= flush_target;
			resp_valid <= 1'b0;
		end
		else if (!freeze)
		begin
			resp_pc    <= req_pc;
			resp_valid <= 1'b1;
			req_pc     <= req_pc + PAIR_BYTES;
		end
	end

	// The response is handed on together with the address it belongs to.
	assign if_pc    = resp_pc;
	assign if_pair  = imem_pair;
	assign if_valid = resp_valid;

endmodule

/* source/if_id.sv */
module if_id import dual_fetch_pkg::*; (
	input  logic              clk,
	input  logic              arst_n,
	input  logic [ADDR_W-1:0] if_pc,
	input  logic [PAIR_W-1:0] if_pair,
	input  logic              if_valid,
	input  logic              stall,
	input  logic              hold,
	input  logic              flush,
	input  logic              left_next,
	output logic [ADDR_W-1:0] id_pc,
	output logic [PAIR_W-1:0] id_pair_new,
	output logic [PAIR_W-1:0] id_pair_old,
	output logic              id_inst_left,
	output logic              id_valid
);

	// A pair is taken in only when fetch moves on.
	// A hold keeps the current new pair so that it can issue by itself.
	logic advance;

	assign advance = !stall && !hold;

	// Control state.
	// Flush drops both the registered pair and any leftover from the old path.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			id_valid     <= 1'b0;
			id_inst_left <= 1'b0;
		end
		else if (flush)
		begin
			id_valid     <= 1'b0;
			id_inst_left <= 1'b0;
		end
		else if (!stall)
		begin
			// The align logic already knows what remains after this cycle.
			// During a hold it clears the flag, because the kept pair
			// then leads the window on its own.
			id_inst_left <= left_next;
			if (!hold)
			begin
				id_valid <= if_valid;
			end
		end
	end

	// Payload registers.
	// The old pair is the previous new pair, so its upper word can lead the
	// next window whenever slot 1 did not issue.
	// id_pc always stays the address of the new pair's first word.
	always_ff @(posedge clk)
	begin
		if (advance)
		begin
			id_pc       <= if_pc;
			id_pair_new <= if_pair;
			id_pair_old <= id_pair_new;
		end
	end

endmodule

/* source/issue_check.sv */
module issue_check import dual_fetch_pkg::*; (
	input  inst_word_t win_inst0,
	input  inst_word_t win_inst1,
	output logic       pair_ok
);

	// What slot 0 writes.
	logic [REG_W-1:0] dst0;
	logic             dst0_valid;
	logic             mem0;

	// What slot 1 reads.
	logic [REG_W-1:0] src1_rs;
	logic [REG_W-1:0] src1_rt;
	logic             rt1_used;
	logic             mem1;

	logic             raw_hazard;
	logic             mem_conflict;

	// Destination of the older instruction.
	// An opcode not listed here is taken to write rt, like an immediate ALU op.
	// That refuses a few safe pairs but never lets a true dependence through.
	always_comb
	begin
		dst0       = win_inst0.i.rt;
		dst0_valid = 1'b1;
		mem0       = 1'b0;
		case (win_inst0.i.opcode)
			OP_SPECIAL:
			begin
				dst0 = win_inst0.r.rd;
			end
			OP_LW:
			begin
				mem0 = 1'b1;
			end
			OP_SW:
			begin
				dst0_valid = 1'b0;
				mem0       = 1'b1;
			end
			OP_BEQ:
			begin
				dst0_valid = 1'b0;
			end
			default:
			begin
				dst0_valid = 1'b1;
			end
		endcase
	end

	// Sources of the younger instruction.
	// rs is always read, and rt is read by the register format, store and branch.
	always_comb
	begin
		src1_rs  = win_inst1.i.rs;
		src1_rt  = win_inst1.r.rt;
		rt1_used = (win_inst1.i.opcode == OP_SPECIAL) || (win_inst1.i.opcode == OP_SW) ||
			(win_inst1.i.opcode == OP_BEQ);
		mem1     = (win_inst1.i.opcode == OP_LW) || (win_inst1.i.opcode == OP_SW);
	end

	// Register zero never carries a dependence.
	assign raw_hazard = dst0_valid && (dst0 != '0) &&
		((dst0 == src1_rs) || (rt1_used && (dst0 == src1_rt)));

	// There is only one memory port behind issue.
	assign mem_conflict = mem0 && mem1;

	assign pair_ok = !raw_hazard && !mem_conflict;

endmodule

/* source/pair_align.sv */
module pair_align import dual_fetch_pkg::*; (
	input  logic [ADDR_W-1:0] id_pc,
	input  logic [PAIR_W-1:0] id_pair_new,
	input  logic [PAIR_W-1:0] id_pair_old,
	input  logic              id_inst_left,
	input  logic              id_valid,
	input  logic              stall,
	input  logic              pair_ok,
	output inst_word_t        win_inst0,
	output inst_word_t        win_inst1,
	output logic              hold,
	output logic              left_next,
	output logic              issue_valid0,
	output logic [INST_W-1:0] issue_inst0,
	output logic [ADDR_W-1:0] issue_pc0,
	output logic              issue_valid1,
	output logic [INST_W-1:0] issue_inst1,
	output logic [ADDR_W-1:0] issue_pc1
);

	logic [ADDR_W-1:0] win_pc0;
	logic [ADDR_W-1:0] win_pc1;

	// A leftover is the upper word of the old pair, one word below id_pc.
	// It leads the window, and the first new word follows it.
	always_comb
	begin
		if (id_inst_left)
		begin
			win_inst0 = id_pair_old[PAIR_W-1:INST_W];
			win_inst1 = id_pair_new[INST_W-1:0];
			win_pc0   = id_pc - WORD_BYTES;
			win_pc1   = id_pc;
		end
		else
		begin
			win_inst0 = id_pair_new[INST_W-1:0];
			win_inst1 = id_pair_new[PAIR_W-1:INST_W];
			win_pc0   = id_pc;
			win_pc1   = id_pc + WORD_BYTES;
		end
	end

	// Slot 1 never goes without slot 0, so issue stays in program order.
	assign issue_valid0 = id_valid && !stall;
	assign issue_valid1 = issue_valid0 && pair_ok;

	assign issue_inst0 = win_inst0;
	assign issue_pc0   = win_pc0;
	assign issue_inst1 = win_inst1;
	assign issue_pc1   = win_pc1;

	// Without a leftover, an unissued slot 1 becomes the next leftover.
	// With a leftover, both words issuing leaves the upper new word behind.
	// A lone issue with a leftover leaves the whole new pair, which
	// needs one more cycle in place.
	assign left_next = issue_valid0 && (id_inst_left ? issue_valid1 : !issue_valid1);
	assign hold      = issue_valid0 && id_inst_left && !issue_valid1;

endmodule

/* source/dual_fetch_top.sv */
module dual_fetch_top import dual_fetch_pkg::*; (
	input  logic              clk,
	input  logic              arst_n,
	output logic [ADDR_W-1:0] imem_addr,
	output logic              imem_en,
	input  logic [PAIR_W-1:0] imem_pair,
	input  logic              stall,
	input  logic              flush,
	input  logic [ADDR_W-1:0] flush_target,
	output logic              issue_valid0,
	output logic [INST_W-1:0] issue_inst0,
	output logic [ADDR_W-1:0] issue_pc0,
	output logic              issue_valid1,
	output logic [INST_W-1:0] issue_inst1,
	output logic [ADDR_W-1:0] issue_pc1
);

	// Fetch to IF/ID.
	logic [ADDR_W-1:0] if_pc;
	logic [PAIR_W-1:0] if_pair;
	logic              if_valid;

	// IF/ID to the align logic.
	logic [ADDR_W-1:0] id_pc;
	logic [PAIR_W-1:0] id_pair_new;
	logic [PAIR_W-1:0] id_pair_old;
	logic              id_inst_left;
	logic              id_valid;

	// Window and the controls that go back up the pipe.
	inst_word_t        win_inst0;
	inst_word_t        win_inst1;
	logic              pair_ok;
	logic              hold;
	logic              left_next;

	fetch_pc u_fetch_pc (
		.clk          (clk),
		.arst_n       (arst_n),
		.stall        (stall),
		.hold         (hold),
		.flush        (flush),
		.flush_target (flush_target),
		.imem_addr    (imem_addr),
		.imem_en      (imem_en),
		.imem_pair    (imem_pair),
		.if_pc        (if_pc),
		.if_pair      (if_pair),
		.if_valid     (if_valid)
	);

	if_id u_if_id (
		.clk          (clk),
		.arst_n       (arst_n),
		.if_pc        (if_pc),
		.if_pair      (if_pair),
		.if_valid     (if_valid),
		.stall        (stall),
		.hold         (hold),
		.flush        (flush),
		.left_next    (left_next),
		.id_pc        (id_pc),
		.id_pair_new  (id_pair_new),
		.id_pair_old  (id_pair_old),
		.id_inst_left (id_inst_left),
		.id_valid     (id_valid)
	);

	pair_align u_pair_align (
		.id_pc        (id_pc),
		.id_pair_new  (id_pair_new),
		.id_pair_old  (id_pair_old),
		.id_inst_left (id_inst_left),
		.id_valid     (id_valid),
		.stall        (stall),
		.pair_ok      (pair_ok),
		.win_inst0    (win_inst0),
		.win_inst1    (win_inst1),
		.hold         (hold),
		.left_next    (left_next),
		.issue_valid0 (issue_valid0),
		.issue_inst0  (issue_inst0),
		.issue_pc0    (issue_pc0),
		.issue_valid1 (issue_valid1),
		.issue_inst1  (issue_inst1),
		.issue_pc1    (issue_pc1)
	);

	issue_check u_issue_check (
		.win_inst0 (win_inst0),
		.win_inst1 (win_inst1),
		.pair_ok   (pair_ok)
	);

endmodule

/* test/tb_checker.sv */
module tb_checker import dual_fetch_pkg::*; (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              stall,
	input  logic              flush,
	input  logic [ADDR_W-1:0] flush_target,
	input  logic [ADDR_W-1:0] imem_addr,
	input  logic              imem_en,
	input  logic              issue_valid0,
	input  logic [INST_W-1:0] issue_inst0,
	input  logic [ADDR_W-1:0] issue_pc0,
	input  logic              issue_valid1,
	input  logic [INST_W-1:0] issue_inst1,
	input  logic [ADDR_W-1:0] issue_pc1,
	input  logic [INST_W-1:0] mem [256],
	output int                error_count,
	output int                check_count
);

	localparam int IDLE_LIMIT = 20;

	// Address of the next instruction in program order.
	logic [ADDR_W-1:0] exp_pc;
	int                idle_cycles;
	// Whether the next two program words may issue together.
	bit                exp_pair;

	// Memory word at a byte address, wrapping like the memory model.
	function automatic logic [INST_W-1:0] program_word(input logic [ADDR_W-1:0] pc);
		return mem[pc[9:2]];
	endfunction

	function automatic bit is_mem_op(input logic [5:0] op);
		return (op == OP_LW) || (op == OP_SW);
	endfunction

	// Pairing model built from the field layout of the instruction word.
	// R-type writes rd, stores and branches write nothing, the rest write rt.
	function automatic bit pair_allowed(input logic [INST_W-1:0] older,
		input logic [INST_W-1:0] younger);
		logic [5:0] op_old;
		logic [5:0] op_young;
		logic [4:0] dst;
		bit         writes;
		bit         reads_rt;
		bit         hazard;
		op_old   = older[31:26];
		op_young = younger[31:26];
		writes   = (op_old != OP_SW) && (op_old != OP_BEQ);
		dst      = (op_old == OP_SPECIAL) ? older[15:11] : older[20:16];
		reads_rt = (op_young == OP_SPECIAL) || (op_young == OP_SW) || (op_young == OP_BEQ);
		hazard   = writes && (dst != 5'd0) &&
			((dst == younger[25:21]) || (reads_rt && (dst == younger[20:16])));
		return !hazard && !(is_mem_op(op_old) && is_mem_op(op_young));
	endfunction

	// One issued slot must be the next word of the program.
	task automatic check_slot(input int slot, input logic [INST_W-1:0] inst,
		input logic [ADDR_W-1:0] pc);
		logic [INST_W-1:0] want;
		want = program_word(exp_pc);
		check_count++;
		if (pc !== exp_pc || inst !== want)
		begin
			error_count++;
			$display("Mismatch at %0t: slot %0d expected pc %h inst %h, got pc %h inst %h",
				$time, slot, exp_pc, want, pc, inst);
		end
		exp_pc = exp_pc + WORD_BYTES;
	endtask

	// Outputs are read at the rising edge, before any register has moved.
	always @(posedge clk)
	begin
		if (arst_n !== 1'b1)
		begin
			exp_pc      = RESET_PC;
			idle_cycles = 0;
			if (issue_valid0 !== 1'b0 || issue_valid1 !== 1'b0)
			begin
				error_count++;
				$display("An issue valid was high during reset at %0t", $time);
			end
		end
		else
		begin
			// The memory is asked for a whole pair on every cycle.
			if (imem_en !== 1'b1 || imem_addr[2:0] !== 3'b000)
			begin
				error_count++;
				$display("Memory request at %0t is off or not pair aligned, address %h",
					$time, imem_addr);
			end
			if (stall === 1'b1 && (issue_valid0 !== 1'b0 || issue_valid1 !== 1'b0))
			begin
				error_count++;
				$display("An instruction issued during a stall at %0t", $time);
			end
			else if (issue_valid1 === 1'b1 && issue_valid0 !== 1'b1)
			begin
				error_count++;
				$display("Slot 1 issued without slot 0 at %0t", $time);
			end
			else if (issue_valid0 === 1'b1)
			begin
				idle_cycles = 0;
				check_count++;
				// The next two words of the program decide whether slot 1 may go.
				exp_pair = pair_allowed(program_word(exp_pc),
					program_word(exp_pc + WORD_BYTES));
				if (issue_valid1 !== exp_pair)
				begin
					error_count++;
					$display("Mismatch at %0t: pairing at pc %h expected %0b, got %0b",
						$time, exp_pc, exp_pair, issue_valid1);
				end
				// Slot 0 is older, so it is matched first.
				check_slot(0, issue_inst0, issue_pc0);
				if (issue_valid1 === 1'b1)
					check_slot(1, issue_inst1, issue_pc1);
			end
			else if (stall !== 1'b1)
			begin
				// Stalled cycles do not count against liveness.
				idle_cycles++;
				if (idle_cycles == IDLE_LIMIT)
				begin
					error_count++;
					$display("No instruction issued in %0d stall-free cycles up to %0t",
						IDLE_LIMIT, $time);
				end
			end
			// Whatever issues after a flush edge comes from the target.
			if (flush === 1'b1)
				exp_pc = flush_target;
		end
	end

endmodule

/* test/tb_dual_fetch.sv */
module tb_dual_fetch import dual_fetch_pkg::*; ();

	localparam int MEM_WORDS      = 256;
	localparam int TRAFFIC_CYCLES = 2000;
	localparam int ISSUE_LIMIT    = 20;
	// Immediate OR, an immediate ALU op outside the five main opcodes.
	localparam logic [5:0] OP_ORI = 6'b001101;

	logic              clk = 1'b0;
	logic              arst_n;
	logic              stall;
	logic              flush;
	logic [ADDR_W-1:0] flush_target;
	logic [ADDR_W-1:0] imem_addr;
	logic              imem_en;
	logic [PAIR_W-1:0] imem_pair = '0;
	logic              issue_valid0;
	logic [INST_W-1:0] issue_inst0;
	logic [ADDR_W-1:0] issue_pc0;
	logic              issue_valid1;
	logic [INST_W-1:0] issue_inst1;
	logic [ADDR_W-1:0] issue_pc1;
	logic [INST_W-1:0] mem [MEM_WORDS];
	int                error_count;
	int                check_count;
	int                timeout_count;
	int                test_count;
	int                errors_before;

	dual_fetch_top u_dual_fetch_top (
		.clk (clk), .arst_n (arst_n), .imem_addr (imem_addr), .imem_en (imem_en),
		.imem_pair (imem_pair), .stall (stall), .flush (flush), .flush_target (flush_target),
		.issue_valid0 (issue_valid0), .issue_inst0 (issue_inst0), .issue_pc0 (issue_pc0),
		.issue_valid1 (issue_valid1), .issue_inst1 (issue_inst1), .issue_pc1 (issue_pc1)
	);

	tb_checker u_tb_checker (
		.clk (clk), .arst_n (arst_n), .stall (stall), .flush (flush),
		.flush_target (flush_target), .imem_addr (imem_addr), .imem_en (imem_en),
		.issue_valid0 (issue_valid0), .issue_inst0 (issue_inst0), .issue_pc0 (issue_pc0),
		.issue_valid1 (issue_valid1), .issue_inst1 (issue_inst1), .issue_pc1 (issue_pc1),
		.mem (mem), .error_count (error_count), .check_count (check_count)
	);

	always #5 clk = ~clk;

	// Synchronous memory; the pair index wraps at the memory size.
	always @(posedge clk)
	begin
		if (imem_en)
			imem_pair <= {mem[{imem_addr[9:3], 1'b1}], mem[{imem_addr[9:3], 1'b0}]};
	end

	// Registers 0 to 3 only, so neighbors often depend on each other.
	function automatic logic [INST_W-1:0] random_inst();
		int unsigned pick;
		logic [5:0]  op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		pick = $urandom % 16;
		rs   = 5'($urandom % 4);
		rt   = 5'($urandom % 4);
		rd   = 5'($urandom % 4);
		op   = (pick < 4) ? OP_SPECIAL : (pick < 7) ? OP_LW : (pick < 10) ? OP_SW :
			(pick < 13) ? OP_ADDIU : (pick < 15) ? OP_BEQ : OP_ORI;
		if (op == OP_SPECIAL)
			return {op, rs, rt, rd, 5'd0, 6'h21};
		return {op, rs, rt, 16'($urandom)};
	endfunction

	function automatic logic [ADDR_W-1:0] random_target();
		return ADDR_W'($urandom % 128) * PAIR_BYTES;
	endfunction

	function automatic int total_errors();
		return error_count + timeout_count;
	endfunction

	task automatic report_test(input string name);
		test_count++;
		$display("test %0d %s: %0d errors", test_count, name, total_errors() - errors_before);
		errors_before = total_errors();
	endtask

	// Starts and ends just after a falling edge, with stall low.
	task automatic wait_for_issue(input string what);
		bit seen;
		seen = 1'b0;
		for (int n = 0; n < ISSUE_LIMIT && !seen; n++)
		begin
			@(posedge clk);
			seen = (issue_valid0 === 1'b1);
		end
		if (!seen)
		begin
			timeout_count++;
			$display("Timeout: nothing issued within %0d cycles %s", ISSUE_LIMIT, what);
		end
		@(negedge clk);
	endtask

	task automatic drive_traffic();
		for (int n = 0; n < TRAFFIC_CYCLES; n++)
		begin
			stall = ($urandom % 100) < 15;
			flush = ($urandom % 40) == 0;
			if (flush)
				flush_target = random_target();
			@(negedge clk);
		end
		stall = 1'b0;
		flush = 1'b0;
	endtask

	initial
	begin
		void'($urandom(92));
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = random_inst();
		arst_n        = 1'b0;
		stall         = 1'b0;
		flush         = 1'b0;
		flush_target  = '0;
		timeout_count = 0;
		test_count    = 0;
		errors_before = 0;
		repeat (4) @(negedge clk);
		report_test("reset");
		arst_n = 1'b1;
		wait_for_issue("after reset");
		report_test("first issue");
		// One-cycle redirect, then the target must come out first.
		flush        = 1'b1;
		flush_target = random_target();
		@(negedge clk);
		flush = 1'b0;
		wait_for_issue("after a flush");
		report_test("flush");
		drive_traffic();
		report_test("random traffic");
		wait_for_issue("after the traffic stopped");
		report_test("recovery");
		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, total_errors());
		if (total_errors() == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* dual_fetch.f */
source/dual_fetch_pkg.sv
source/fetch_pc.sv
source/if_id.sv
source/issue_check.sv
source/pair_align.sv
source/dual_fetch_top.sv
test/tb_checker.sv
test/tb_dual_fetch.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dual_fetch
FILELIST  ?= dual_fetch.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SOURCES := $(wildcard source/*.sv test/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
